/* hw/jam_settings.svh */
`ifndef JAM_SETTINGS_SVH
`define JAM_SETTINGS_SVH

// Workers per problem, equal to the number of jobs
`define JAM_WORKERS 8

// One worker or job index
`define JAM_INDEX_W 3

// Single entry of the cost table
`define JAM_COST_W 7

// Sum of eight costs
// Largest reachable total is 1016
`define JAM_TOTAL_W 10

// Match counter wide enough for all 40320 permutations
`define JAM_COUNT_W 16

// Minimum starts above any reachable total
`define JAM_MIN_INIT {`JAM_TOTAL_W{1'b1}}

`endif

/* hw/jamPkg.sv */
`include "jam_settings.svh"

package jamPkg;

    // Worker or job number
    typedef logic [`JAM_INDEX_W-1:0] indexT;

    // One cost table entry
    typedef logic [`JAM_COST_W-1:0] costT;

    // Total cost of one assignment
    typedef logic [`JAM_TOTAL_W-1:0] totalT;

    // Number of assignments that reach the minimum
    typedef logic [`JAM_COUNT_W-1:0] countT;

    // Entry j holds the worker placed on job j
    typedef indexT [`JAM_WORKERS-1:0] assignT;

    // Lookup request toward the cost table
    typedef struct packed {
        indexT worker;
        indexT job;
    } queryT;

    // Finished score handed from walker to tracker
    typedef struct packed {
        totalT total;
        // Set on the score of the final assignment
        logic  done;
    } scoreT;

endpackage

/* hw/permutationStepper.sv */
`timescale 1ns/1ns

`include "jam_settings.svh"

module permutationStepper
    import jamPkg::*;
(
    input  logic   CLK,
    input  logic   RST,
    input  logic   advance,
    output assignT assignment,
    output logic   last
);

    // Highest index whose entry exceeds its successor
    indexT  pivot;
    logic   hasPivot;

    // Largest tail entry still below the pivot entry
    indexT  partner;

    // Assignment after the swap, then after the tail reversal
    assignT swapped;
    assignT nextAssign;

    // Pivot search
    // Later matches overwrite earlier ones so the highest index wins
    always_comb
    begin
        hasPivot = 1'b0;
        pivot = '0;
        for (int i = 0; i < `JAM_WORKERS - 1; i++)
        begin
            if (assignment[i] > assignment[i + 1])
            begin
                hasPivot = 1'b1;
                pivot = indexT'(i);
            end
        end
    end

    // Tail right of the pivot is ascending
    // so the last entry below the pivot entry is the largest such one
    always_comb
    begin
        partner = pivot;
        for (int k = 0; k < `JAM_WORKERS; k++)
        begin
            if ((k > int'(pivot)) && (assignment[k] < assignment[pivot]))
            begin
                partner = indexT'(k);
            end
        end
    end

    // Exchange pivot and partner
    always_comb
    begin
        swapped = assignment;
        swapped[pivot] = assignment[partner];
        swapped[partner] = assignment[pivot];
    end

    // Reverse the tail
    // Tail stays ascending after the swap
    // Reversal makes it descending
    always_comb
    begin
        nextAssign = swapped;
        for (int j = 0; j < `JAM_WORKERS; j++)
        begin
            if (j > int'(pivot))
            begin
                nextAssign[j] = swapped[int'(pivot) + `JAM_WORKERS - j];
            end
        end
    end

    // Ascending order has no pivot and ends the enumeration
    assign last = !hasPivot;

    // Start from descending order, worker 7 on job 0
    always_ff @(posedge CLK or posedge RST)
    begin
        if (RST)
        begin
            for (int j = 0; j < `JAM_WORKERS; j++)
            begin
                assignment[j] <= indexT'(`JAM_WORKERS - 1 - j);
            end
        end
        else if (advance && !last)
        begin
            // Final assignment is held once reached
            assignment <= nextAssign;
        end
    end

endmodule

/* hw/costWalker.sv */
`timescale 1ns/1ns

`include "jam_settings.svh"

module costWalker
    import jamPkg::*;
(
    input  logic   CLK,
    input  logic   RST,
    input  assignT assignment,
    input  logic   last,
    input  costT   cost,
    output queryT  query,
    output logic   advance,
    output scoreT  score,
    output logic   scoreValid
);

    // Slot of the final job in an assignment
    localparam indexT LAST_SLOT = indexT'(`JAM_WORKERS - 1);

    // Job number of the next query to issue
    indexT slot;

    // Cleared after the final assignment has been issued
    logic  running;

    // Query on W/J is live and its cost is sampled next edge
    logic  queryValid;

    // Copy of last taken when the current assignment was released
    logic  lastSeen;

    // Running sum of sampled costs
    totalT sum;
    totalT partial;
    totalT nextSum;

    // Cost of the query currently on the bus belongs to the final job
    logic  finalSample;

    // Job 0 restarts the sum
    assign partial = (query.job == '0) ? '0 : sum;
    assign nextSum = partial + totalT'(cost);

    assign finalSample = queryValid && (query.job == LAST_SLOT);

    // Stepper moves on as the slot 7 query is registered
    assign advance = running && (slot == LAST_SLOT);

    // Slot sequencing and query issue
    always_ff @(posedge CLK or posedge RST)
    begin
        if (RST)
        begin
            slot <= '0;
            running <= 1'b1;
            queryValid <= 1'b0;
            lastSeen <= 1'b0;
            scoreValid <= 1'b0;
            query <= '0;
        end
        else
        begin
            queryValid <= running;
            // Strobe follows the slot 7 sample by one cycle
            scoreValid <= finalSample;
            if (running)
            begin
                query.worker <= assignment[slot];
                query.job <= slot;
                // Wraps from 7 back to 0
                slot <= slot + 1'b1;
                if (advance)
                begin
                    lastSeen <= last;
                    // Nothing left to issue after the final assignment
                    if (last)
                    begin
                        running <= 1'b0;
                    end
                end
            end
        end
    end

    // Accumulate one cost per cycle
    always_ff @(posedge CLK)
    begin
        if (queryValid)
        begin
            sum <= nextSum;
        end
        if (finalSample)
        begin
            score.total <= nextSum;
            score.done <= lastSeen;
        end
    end

endmodule

/* hw/minCostTracker.sv */
`timescale 1ns/1ns

`include "jam_settings.svh"

module minCostTracker
    import jamPkg::*;
(
    input  logic  CLK,
    input  logic  RST,
    input  scoreT score,
    input  logic  scoreValid,
    output totalT minCost,
    output countT matchCount,
    output logic  valid
);

    // Incoming total beats the best so far
    logic better;

    // Incoming total ties the best so far
    logic equal;

    assign better = score.total < minCost;
    assign equal = score.total == minCost;

    always_ff @(posedge CLK or posedge RST)
    begin
        if (RST)
        begin
            minCost <= `JAM_MIN_INIT;
            matchCount <= '0;
            valid <= 1'b0;
        end
        else if (scoreValid)
        begin
            if (better)
            begin
                // New minimum with this assignment as its only match so far
                minCost <= score.total;
                matchCount <= countT'(1);
            end
            else if (equal)
            begin
                matchCount <= matchCount + 1'b1;
            end
            // Final assignment scored
            // Valid then holds until reset
            if (score.done)
            begin
                valid <= 1'b1;
            end
        end
    end

endmodule

/* hw/jamTop.sv */
`timescale 1ns/1ns

module jamTop
    import jamPkg::*;
(
    input  logic  CLK,
    input  logic  RST,
    output indexT W,
    output indexT J,
    input  costT  Cost,
    output countT MatchCount,
    output totalT MinCost,
    output logic  Valid
);

    // Current assignment from the stepper
    assignT assignment;
    logic   last;
    logic   advance;

    // Registered lookup request
    queryT  query;

    // Finished score toward the tracker
    scoreT  score;
    logic   scoreValid;

    // Lookup port driven straight from the walker registers
    assign W = query.worker;
    assign J = query.job;

    permutationStepper stepper (
        .CLK        (CLK),
        .RST        (RST),
        .advance    (advance),
        .assignment (assignment),
        .last       (last)
    );

    costWalker walker (
        .CLK        (CLK),
        .RST        (RST),
        .assignment (assignment),
        .last       (last),
        .cost       (Cost),
        .query      (query),
        .advance    (advance),
        .score      (score),
        .scoreValid (scoreValid)
    );

    minCostTracker tracker (
        .CLK        (CLK),
        .RST        (RST),
        .score      (score),
        .scoreValid (scoreValid),
        .minCost    (MinCost),
        .matchCount (MatchCount),
        .valid      (Valid)
    );

endmodule

/* tb/jamTb.sv */
`timescale 1ns/1ns

`include "jam_settings.svh"

module jamTb
    import jamPkg::*;
();

    // Clock period in ns
    localparam int period = 4;
    // 8! assignments per full search
    localparam int permCount = 40320;
    // One query per job for every assignment
    localparam int runCycles = permCount * `JAM_WORKERS;
    // Bound on the wait for Valid after reset release
    localparam int validLimit = runCycles + 64;
    // Five full runs plus half a run for the aborted run and the resets
    localparam int watchCycles = 5 * runCycles + runCycles / 2;
    // Cycles into a run before the mid-search reset
    localparam int abortCycles = 100000;

    logic  CLK;
    logic  RST = 1'b1;
    indexT W;
    indexT J;
    costT  Cost;
    countT MatchCount;
    totalT MinCost;
    logic  Valid;

    // Cost table model indexed by worker then job
    costT costTable [`JAM_WORKERS][`JAM_WORKERS] = '{default: '0};
    // Table built by a test before it reaches the model
    costT nextTable [`JAM_WORKERS][`JAM_WORKERS];

    int checks = 0;
    int errors = 0;
    logic [15:0] lfsrState = 16'd67;

    // Query monitor state for the diagonal run only
    logic monitorOn = 1'b0;
    int   querySlot = 0;
    int   groupsSeen = 0;
    logic [`JAM_WORKERS-1:0] workersSeen = '0;

    // Random table result reused after the mid-search reset
    totalT randomMin;
    int    randomCount;

    jamTop jamTop_i (
        .CLK        (CLK),
        .RST        (RST),
        .W          (W),
        .J          (J),
        .Cost       (Cost),
        .MatchCount (MatchCount),
        .MinCost    (MinCost),
        .Valid      (Valid)
    );

    // Environment answers within the same cycle
    assign Cost = costTable[W][J];

    initial
    begin
        CLK = 1'b0;
        forever
            #(period / 2) CLK = ~CLK;
    end

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        checks++;
        assert (actual === expected)
        else
        begin
            errors++;
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, actual, expected);
        end
    endtask

    // Outputs as they must look while reset holds
    task automatic checkIdle();
        checkValue("Valid", Valid, 1'b0);
        checkValue("MatchCount", MatchCount, '0);
        checkValue("MinCost", MinCost, (1 << `JAM_TOTAL_W) - 1);
        checkValue("W", W, '0);
        checkValue("J", J, '0);
    endtask

    // Eight cycles of reset with optional idle checks
    task automatic resetDut(input bit watch);
        @(posedge CLK);
        RST <= 1'b1;
        repeat (8)
        begin
            @(negedge CLK);
            if (watch)
                checkIdle();
            @(posedge CLK);
        end
        RST <= 1'b0;
        // First query only appears on the next edge
        @(negedge CLK);
        if (watch)
            checkIdle();
    endtask

    task automatic applyTable();
        @(posedge CLK);
        for (int w = 0; w < `JAM_WORKERS; w++)
            for (int j = 0; j < `JAM_WORKERS; j++)
                costTable[w][j] <= nextTable[w][j];
    endtask

    // Galois LFSR of 16 bits
    function automatic logic [15:0] lfsrNext(input logic [15:0] state);
        logic [15:0] shifted;
        shifted = state >> 1;
        if (state[0])
            shifted = shifted ^ 16'hB400;
        return shifted;
    endfunction

    // One LFSR step per bit taken
    task automatic takeBits(input int width, output logic [15:0] value);
        value = '0;
        for (int b = 0; b < width; b++)
        begin
            value[b] = lfsrState[0];
            lfsrState = lfsrNext(lfsrState);
        end
    endtask

    // Cost of one assignment where entry j is the worker on job j
    function automatic int totalOf(input indexT [`JAM_WORKERS-1:0] perm);
        int sum;
        sum = 0;
        for (int j = 0; j < `JAM_WORKERS; j++)
            sum += int'(nextTable[perm[j]][j]);
        return sum;
    endfunction

    // Exhaustive search over nextTable in Heap's order
    task automatic searchTable(output totalT bestTotal, output int bestCount);
        indexT [`JAM_WORKERS-1:0] perm;
        int    stack [`JAM_WORKERS];
        int    best;
        int    total;
        int    i;
        indexT tmp;
        bit    moreLeft;
        for (int k = 0; k < `JAM_WORKERS; k++)
        begin
            perm[k] = indexT'(k);
            stack[k] = 0;
        end
        best = 1 << 30;
        bestCount = 0;
        i = 1;
        moreLeft = 1'b1;
        while (moreLeft)
        begin
            total = totalOf(perm);
            if (total < best)
            begin
                best = total;
                bestCount = 1;
            end
            else if (total == best)
                bestCount++;
            while (i < `JAM_WORKERS && stack[i] >= i)
            begin
                stack[i] = 0;
                i++;
            end
            if (i >= `JAM_WORKERS)
                moreLeft = 1'b0;
            else
            begin
                // Even level swaps with the head and odd level with its counter
                tmp = perm[i];
                perm[i] = perm[(i % 2 == 0) ? 0 : stack[i]];
                perm[(i % 2 == 0) ? 0 : stack[i]] = tmp;
                stack[i]++;
                i = 1;
            end
        end
        bestTotal = totalT'(best);
    endtask

    // Wait for Valid, check results, then check that they hold
    task automatic finishRun(input totalT expMin, input int expCount);
        int    cycles;
        indexT heldW;
        indexT heldJ;
        cycles = 0;
        while (Valid !== 1'b1 && cycles < validLimit)
        begin
            @(negedge CLK);
            cycles++;
        end
        checks++;
        assert (Valid === 1'b1)
        else
        begin
            errors++;
            $display("Valid did not rise within %0d cycles of reset", validLimit);
        end
        checks++;
        assert (cycles >= runCycles)
        else
        begin
            errors++;
            $display("Valid rose after %0d cycles, before all assignments were scored", cycles);
        end
        checkValue("MinCost", MinCost, expMin);
        checkValue("MatchCount", MatchCount, expCount);
        heldW = W;
        heldJ = J;
        repeat (16)
            @(negedge CLK);
        // No new queries and stable results once done
        checkValue("Valid", Valid, 1'b1);
        checkValue("W", W, heldW);
        checkValue("J", J, heldJ);
        checkValue("MinCost", MinCost, expMin);
    endtask

    // Each group of eight queries covers jobs 0..7 with distinct workers
    always @(negedge CLK)
    begin
        if (monitorOn && groupsSeen < permCount)
        begin
            checkValue("J", J, querySlot);
            workersSeen[W] = 1'b1;
            if (querySlot == `JAM_WORKERS - 1)
            begin
                checkValue("W set", workersSeen, {`JAM_WORKERS{1'b1}});
                workersSeen = '0;
                querySlot = 0;
                groupsSeen++;
            end
            else
                querySlot++;
        end
    end

    task automatic uniformTest();
        for (int w = 0; w < `JAM_WORKERS; w++)
            for (int j = 0; j < `JAM_WORKERS; j++)
                nextTable[w][j] = costT'(5);
        applyTable();
        resetDut(1'b0);
        finishRun(totalT'(5 * `JAM_WORKERS), permCount);
    endtask

    task automatic diagonalTest();
        for (int w = 0; w < `JAM_WORKERS; w++)
            for (int j = 0; j < `JAM_WORKERS; j++)
                nextTable[w][j] = (w == j) ? costT'(0) : costT'(100);
        applyTable();
        resetDut(1'b0);
        @(posedge CLK);
        monitorOn = 1'b1;
        finishRun('0, 1);
        monitorOn = 1'b0;
        checkValue("query groups", groupsSeen, permCount);
    endtask

    // Every entry at the largest cost so each total reaches 1016
    task automatic jobOnlyTest();
        int colSum;
        colSum = 0;
        for (int j = 0; j < `JAM_WORKERS; j++)
        begin
            for (int w = 0; w < `JAM_WORKERS; w++)
                nextTable[w][j] = costT'((1 << `JAM_COST_W) - 1);
            colSum += (1 << `JAM_COST_W) - 1;
        end
        applyTable();
        resetDut(1'b0);
        finishRun(totalT'(colSum), permCount);
    endtask

    task automatic randomTest();
        logic [15:0] bits;
        for (int w = 0; w < `JAM_WORKERS; w++)
            for (int j = 0; j < `JAM_WORKERS; j++)
            begin
                takeBits(`JAM_COST_W, bits);
                nextTable[w][j] = costT'(bits);
            end
        searchTable(randomMin, randomCount);
        applyTable();
        resetDut(1'b0);
        finishRun(randomMin, randomCount);
    endtask

    // Abort a run with the random table still loaded, then rerun it
    task automatic midSearchTest();
        resetDut(1'b0);
        repeat (abortCycles)
            @(posedge CLK);
        @(negedge CLK);
        checkValue("Valid", Valid, 1'b0);
        resetDut(1'b1);
        finishRun(randomMin, randomCount);
    endtask

    initial
    begin
        resetDut(1'b1);
        uniformTest();
        diagonalTest();
        jobOnlyTest();
        randomTest();
        midSearchTest();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

    // Watchdog
    initial
    begin
        repeat (watchCycles)
            @(posedge CLK);
        $display("Watchdog expired after %0d cycles, the tests did not finish", watchCycles);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        $display("Something failed");
        $finish;
    end

endmodule

/* jam.f */
+incdir+hw
hw/jamPkg.sv
hw/permutationStepper.sv
hw/costWalker.sv
hw/minCostTracker.sv
hw/jamTop.sv
tb/jamTb.sv

/* Makefile */
SIM      ?= verilator
SIMFLAGS ?= --binary --timing --assert --timescale 1ns/1ns -Wno-fatal
TOP      ?= jamTb
FILELIST ?= jam.f
BUILDDIR ?= obj_dir
PASSMSG  := Everything OK

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) --Mdir $(BUILDDIR) -f $(FILELIST)
	@out="$$(./$(BUILDDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASSMSG)"

clean:
	rm -rf $(BUILDDIR)
